// ==== sources.f ====
+incdir+verilog
verilog/fft_pkg.sv
verilog/fft_ifs.sv
verilog/sample_memory.sv
verilog/fft_agu.sv
verilog/fp4_butterfly.sv
verilog/fft_core.sv
verilog/fft_io_ctrl.sv
verilog/fft_top.sv
testbench/tb_fft.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run tb_fft with Verilator, exit status 1 on any failure
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_fft -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_fft > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== testbench/tb_fft.sv ====
// ------------------------------------------------
// directed tests of the FP4 FFT, stops at the first error
// expected bins come from a real valued FP4 rounding model
// ------------------------------------------------
`include "fft_settings.svh"

module tb_fft;
    timeunit 1ns;
    timeprecision 1ps;
    import fft_pkg::*;

    localparam int MAX_CYCLES = 20000;  // whole sequence is under 2k cycles
    localparam int WAIT_LIMIT = 1000;   // N = 32 core run alone is 400 cycles

    logic   clk;
    logic   rst;
    log2n_t log2n;
    cplx_t  data_in;
    logic   data_in_valid;
    logic   fft_ready;
    logic   done;
    logic   error;
    cplx_t  data_out;
    logic   data_out_valid;

    cplx_t       frame_in   [`FFT_MAX_N];  // time samples, natural order
    cplx_t       frame_out  [`FFT_MAX_N];  // bins as they stream out
    cplx_t       expect_out [`FFT_MAX_N];
    logic [31:0] rng_state;
    int          cycle_cnt = 0;

    fft_top uut (
        .clk            (clk),
        .rst            (rst),
        .log2n          (log2n),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .fft_ready      (fft_ready),
        .done           (done),
        .error          (error),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            fail_run("run stopped at the cycle limit before the tests finished");
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_cplx(input string name, input cplx_t exp_v, input cplx_t got);
        if (got !== exp_v) begin
            fail_run($sformatf("Error at %0d ns: %s expected %h, got %h",
                               $time, name, exp_v, got));
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic got);
        if (got !== exp_v) begin
            fail_run($sformatf("Error at %0d ns: %s expected %b, got %b",
                               $time, name, exp_v, got));
        end
    endtask

    // xorshift32, idle cycles of 0 to 2 between samples
    function automatic int pick_gap();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return int'(x % 3);
    endfunction

    function automatic real fp4_mag(input int code);
        case (code)
            0: return 0.0;
            1: return 0.5;
            2: return 1.0;
            3: return 1.5;
            4: return 2.0;
            5: return 3.0;
            6: return 4.0;
            default: return 6.0;
        endcase
    endfunction

    function automatic real fp4_val(input fp4_t v);
        return v[3] ? -fp4_mag(int'(v[2:0])) : fp4_mag(int'(v[2:0]));
    endfunction

    // nearest E2M1 value, a tie picks the even mantissa, anything past 6 lands on 6
    function automatic fp4_t fp4_round(input real r);
        real m;
        real d;
        real best;
        int  code;
        m = (r < 0.0) ? -r : r;
        code = 0;
        best = m;
        for (int c = 1; c < 8; c++) begin
            d = (m > fp4_mag(c)) ? m - fp4_mag(c) : fp4_mag(c) - m;
            if (d < best || (d == best && c % 2 == 0)) begin
                code = c;
                best = d;
            end
        end
        return {(r < 0.0) && (code != 0), code[2:0]};  // zero is never negative
    endfunction

    function automatic fp4_t fp4_add(input fp4_t p, input fp4_t q);
        return fp4_round(fp4_val(p) + fp4_val(q));
    endfunction

    function automatic cplx_t cplx_of(input real re, input real im);
        return {fp4_round(re), fp4_round(im)};
    endfunction

    // entered on a falling edge, leaves one falling edge after the last sample
    task automatic send_frame(input log2n_t size, input bit gaps);
        int n;
        int gap;
        int waited;
        n = 1 << size;
        waited = 0;
        while (fft_ready !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) fail_run("fft_ready never rose for a new frame");
        end
        for (int i = 0; i < n; i++) begin
            if (gaps && i > 0) begin
                gap = pick_gap();
                data_in_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            log2n         = size;
            data_in       = frame_in[i];
            data_in_valid = 1'b1;
            @(negedge clk);
            if (i == 0) check_bit("fft_ready", 1'b0, fft_ready);  // busy after first sample
        end
        data_in_valid = 1'b0;
    endtask

    task automatic run_frame(input log2n_t size, input bit gaps);
        int n;
        int waited;
        n = 1 << size;
        send_frame(size, gaps);
        waited = 0;
        while (done !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) fail_run("done never pulsed after a full frame");
        end
        @(negedge clk);
        check_bit("done", 1'b0, done);                      // one cycle pulse
        check_bit("data_out_valid", 1'b0, data_out_valid);
        @(negedge clk);                                      // two cycles after done
        for (int i = 0; i < n; i++) begin
            check_bit("data_out_valid", 1'b1, data_out_valid);
            frame_out[i] = data_out;
            @(negedge clk);
        end
        check_bit("data_out_valid", 1'b0, data_out_valid);  // exactly N outputs
        check_bit("fft_ready", 1'b1, fft_ready);
    endtask

    task automatic compare_frame(input int n);
        for (int i = 0; i < n; i++) begin
            check_cplx($sformatf("data_out[%0d]", i), expect_out[i], frame_out[i]);
        end
    endtask

    // impulse of 1.0 at x[pos], pos is 0 or N/2, so bin k is (-1)**(2*k*pos/N)
    task automatic impulse_test(input log2n_t size, input int pos, input bit gaps);
        int n;
        n = 1 << size;
        for (int i = 0; i < n; i++) begin
            frame_in[i]   = (i == pos) ? cplx_of(1.0, 0.0) : cplx_of(0.0, 0.0);
            expect_out[i] = ((i * pos * 2 / n) % 2) ? cplx_of(-1.0, 0.0) : cplx_of(1.0, 0.0);
        end
        run_frame(size, gaps);
        compare_frame(n);
    endtask

    // constant real input, bin 0 is the value doubled once per stage
    task automatic const_test(input log2n_t size, input real value, input bit gaps);
        int   n;
        fp4_t sum;
        n = 1 << size;
        sum = fp4_round(value);
        repeat (size) sum = fp4_add(sum, sum);
        for (int i = 0; i < n; i++) begin
            frame_in[i]   = cplx_of(value, 0.0);
            expect_out[i] = (i == 0) ? {sum, fp4_round(0.0)} : cplx_of(0.0, 0.0);
        end
        run_frame(size, gaps);
        compare_frame(n);
    endtask

    task automatic bad_log2n_test(input log2n_t bad);
        log2n         = bad;
        data_in       = cplx_of(1.0, 0.0);
        data_in_valid = 1'b1;
        @(negedge clk);
        data_in_valid = 1'b0;
        if (error !== 1'b1) fail_run($sformatf("error did not pulse for log2n = %0d", bad));
        @(negedge clk);
        check_bit("error", 1'b0, error);
        repeat (20) begin
            check_bit("data_out_valid", 1'b0, data_out_valid);  // sample was dropped
            check_bit("fft_ready", 1'b1, fft_ready);
            @(negedge clk);
        end
        impulse_test(3, 0, 1'b0);  // next good frame
    endtask

    initial begin
        rst           = 1'b0;
        log2n         = 3'd1;
        data_in       = '0;
        data_in_valid = 1'b0;
        rng_state     = 32'd84;
        repeat (4) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_bit("fft_ready", 1'b1, fft_ready);
        check_bit("done", 1'b0, done);
        check_bit("error", 1'b0, error);
        check_bit("data_out_valid", 1'b0, data_out_valid);

        impulse_test(3, 0, 1'b0);
        impulse_test(5, 0, 1'b0);
        impulse_test(1, 1, 1'b0);   // x[1], N = 2
        impulse_test(2, 2, 1'b0);   // x[2], N = 4
        const_test(2, 0.5, 1'b0);
        const_test(4, 1.0, 1'b0);   // bin 0 saturates
        bad_log2n_test(3'd0);
        bad_log2n_test(3'd6);

        // back to back frames with idle gaps
        impulse_test(3, 0, 1'b1);
        const_test(2, 0.5, 1'b1);
        impulse_test(5, 0, 1'b1);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== verilog/fft_top.sv ====
// ------------------------------------------------
// FP4 radix-2 FFT, N = 2**log2n with log2n from 1 to 5
// no output back-pressure, input only while fft_ready
// ------------------------------------------------

module fft_top (
    input  logic            clk,
    input  logic            rst,
    input  fft_pkg::log2n_t log2n,
    input  fft_pkg::cplx_t  data_in,
    input  logic            data_in_valid,
    output logic            fft_ready,
    output logic            done,
    output logic            error,
    output fft_pkg::cplx_t  data_out,
    output logic            data_out_valid
);
    import fft_pkg::*;

    logic   core_start;
    logic   core_busy;
    log2n_t frame_log2n;   // latched at the first sample

    mem_port_if io_port ();
    mem_port_if core_port ();
    agu_if      agu ();

    sample_memory u_mem (
        .clk       (clk),
        .rst       (rst),
        .core_busy (core_busy),
        .io_port   (io_port.mem),
        .core_port (core_port.mem)
    );

    fft_agu u_agu (.clk(clk), .rst(rst), .agu(agu.gen));

    fft_core u_core (
        .clk       (clk),
        .rst       (rst),
        .start     (core_start),
        .log2n     (frame_log2n),
        .core_busy (core_busy),
        .done      (done),
        .mem       (core_port.user),
        .agu       (agu.ctrl)
    );

    fft_io_ctrl u_io (
        .clk            (clk),
        .rst            (rst),
        .log2n          (log2n),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .core_done      (done),
        .core_start     (core_start),
        .frame_log2n    (frame_log2n),
        .fft_ready      (fft_ready),
        .error          (error),
        .data_out_valid (data_out_valid),
        .data_out       (data_out),
        .mem            (io_port.user)
    );

endmodule

// ==== verilog/fft_io_ctrl.sv ====
// ------------------------------------------------
// frame load in bit-reversed order, start, readout
// log2n checked only at the first sample of a frame
// ------------------------------------------------
`include "fft_settings.svh"

module fft_io_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  fft_pkg::log2n_t log2n,
    input  fft_pkg::cplx_t  data_in,
    input  logic            data_in_valid,
    input  logic            core_done,
    output logic            core_start,
    output fft_pkg::log2n_t frame_log2n,
    output logic            fft_ready,
    output logic            error,
    output logic            data_out_valid,
    output fft_pkg::cplx_t  data_out,
    mem_port_if.user        mem
);
    import fft_pkg::*;

    io_state_e state_q;
    addr_t     count_q;    // sample count on load, read address on readout
    addr_t     n_m1;       // N - 1 of the frame
    logic      tail_q;     // last address issued, one output still due
    logic      log2n_ok;
    logic      take;
    logic      rd_issue;

    function automatic addr_t bit_rev(input addr_t cnt, input log2n_t nbits);
        addr_t rev;
        rev = '0;
        for (int i = 0; i < `FFT_MAX_LOG2N; i++) begin
            if (i < nbits) begin
                rev[nbits - 1 - i] = cnt[i];
            end
        end
        return rev;
    endfunction

    assign log2n_ok = (log2n != '0) && (log2n <= log2n_t'(`FFT_MAX_LOG2N));
    assign n_m1     = addr_t'((1 << frame_log2n) - 1);
    assign take     = (state_q == LOAD) && data_in_valid && (!fft_ready || log2n_ok);
    assign rd_issue = (state_q == READ) && !tail_q;

    // first sample has count 0, so a stale frame_log2n still maps it to 0
    assign mem.wr_en   = take;
    assign mem.wr_addr = bit_rev(count_q, frame_log2n);
    assign mem.wr_data = data_in;
    assign mem.rd_addr = count_q;
    assign data_out    = mem.rd_data;   // valid lags the address by one clock

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q        <= LOAD;
            count_q        <= '0;
            tail_q         <= 1'b0;
            frame_log2n    <= '0;
            fft_ready      <= 1'b1;
            error          <= 1'b0;
            core_start     <= 1'b0;
            data_out_valid <= 1'b0;
        end else begin
            error          <= (state_q == LOAD) && fft_ready && data_in_valid && !log2n_ok;
            core_start     <= 1'b0;
            data_out_valid <= rd_issue;
            case (state_q)
                LOAD: if (take) begin
                    if (fft_ready) begin
                        frame_log2n <= log2n;   // frame size fixed from here on
                        fft_ready   <= 1'b0;
                    end
                    if (!fft_ready && count_q == n_m1) begin
                        count_q    <= '0;
                        core_start <= 1'b1;
                        state_q    <= PROCESS;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                PROCESS: if (core_done) state_q <= READ;
                default: begin   // READ
                    if (tail_q) begin
                        tail_q    <= 1'b0;
                        count_q   <= '0;
                        fft_ready <= 1'b1;
                        state_q   <= LOAD;
                    end else begin
                        count_q <= count_q + 1'b1;
                        if (count_q == n_m1) tail_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    a_no_output_on_load: assert property (@(posedge clk) disable iff (!rst)
        (state_q == LOAD) |-> !data_out_valid);

endmodule

// ==== verilog/fft_core.sv ====
// ------------------------------------------------
// in-place butterfly scheduler, 5 clocks per butterfly
// start must come with a valid, stable log2n
// ------------------------------------------------

module fft_core (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  fft_pkg::log2n_t log2n,
    output logic            core_busy,
    output logic            done,
    mem_port_if.user        mem,
    agu_if.ctrl             agu
);
    import fft_pkg::*;

    core_state_e state_q, state_d;
    cplx_t a_q, b_q;   // operands from memory
    cplx_t y_q;        // held for the second write
    cplx_t x_w, y_w;

    fp4_butterfly u_bfly (
        .a      (a_q),
        .b      (b_q),
        .tw_idx (agu.tw_idx),
        .x      (x_w),
        .y      (y_w)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start) state_d = READ_A;
            READ_A:  state_d = READ_B;
            READ_B:  state_d = COMPUTE;
            COMPUTE: state_d = WRITE_X;
            WRITE_X: state_d = WRITE_Y;
            WRITE_Y: state_d = agu.last ? DONE : READ_A;
            default: state_d = IDLE;   // DONE
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) state_q <= IDLE;
        else      state_q <= state_d;
    end

    always_ff @(posedge clk) begin
        if (state_q == READ_B)  a_q <= mem.rd_data;   // data for idx_a
        if (state_q == COMPUTE) b_q <= mem.rd_data;   // data for idx_b
        if (state_q == WRITE_X) y_q <= y_w;
    end

    assign mem.rd_addr = (state_q == READ_A) ? agu.idx_a : agu.idx_b;
    assign mem.wr_en   = (state_q == WRITE_X) || (state_q == WRITE_Y);
    assign mem.wr_addr = (state_q == WRITE_X) ? agu.idx_a : agu.idx_b;
    assign mem.wr_data = (state_q == WRITE_X) ? x_w : y_q;   // x straight from the butterfly

    assign agu.clear = start && (state_q == IDLE);
    assign agu.step  = (state_q == WRITE_Y) && !agu.last;
    assign agu.log2n = log2n;

    assign core_busy = start || (state_q != IDLE);   // owns memory from the start pulse
    assign done      = (state_q == DONE);

    // butterfly writes stay inside the current frame
    a_write_in_frame: assert property (@(posedge clk) disable iff (!rst)
        mem.wr_en |-> (int'(mem.wr_addr) < (1 << log2n)));

endmodule

// ==== verilog/fp4_butterfly.sv ====
// ------------------------------------------------
// combinational FP4 butterfly, x = a + W*b, y = a - W*b
// every real op rounds to nearest even, clamps to 6
// ------------------------------------------------

module fp4_butterfly (
    input  fft_pkg::cplx_t  a,
    input  fft_pkg::cplx_t  b,
    input  fft_pkg::tw_idx_t tw_idx,
    output fft_pkg::cplx_t  x,
    output fft_pkg::cplx_t  y
);
    import fft_pkg::*;

    cplx_t w;
    fp4_t  p_rr, p_ii, p_ri, p_ir;   // four real products
    fp4_t  wb_re, wb_im;

    // fp4 to signed count of halves
    function automatic logic signed [8:0] to_half(input fp4_t v);
        logic signed [8:0] mag;
        case (v[2:0])
            3'd0: mag = 9'sd0;
            3'd1: mag = 9'sd1;    // 0.5
            3'd2: mag = 9'sd2;
            3'd3: mag = 9'sd3;
            3'd4: mag = 9'sd4;
            3'd5: mag = 9'sd6;
            3'd6: mag = 9'sd8;
            default: mag = 9'sd12; // 6.0
        endcase
        return v[3] ? -mag : mag;
    endfunction

    // signed count of quarters back to fp4, midpoints go to even mantissa
    function automatic fp4_t round_q(input logic signed [8:0] q);
        logic [8:0] m;
        logic [2:0] code;
        m = q[8] ? -q : q;
        if (m <= 9'd1)       code = 3'd0;   // 0.25 -> 0
        else if (m <= 9'd2)  code = 3'd1;
        else if (m <= 9'd5)  code = 3'd2;   // 0.75 and 1.25 -> 1.0
        else if (m <= 9'd6)  code = 3'd3;
        else if (m <= 9'd10) code = 3'd4;   // 1.75 and 2.5 -> 2.0
        else if (m <= 9'd13) code = 3'd5;
        else if (m <= 9'd20) code = 3'd6;   // 3.5 and 5 -> 4.0
        else                 code = 3'd7;   // clamp at 6
        return {q[8] && (code != 3'd0), code};  // no negative zero
    endfunction

    function automatic fp4_t fmul(input fp4_t p, input fp4_t q);
        return round_q(to_half(p) * to_half(q));   // halves * halves = quarters
    endfunction

    function automatic fp4_t fadd(input fp4_t p, input fp4_t q, input logic sub);
        logic signed [8:0] hp;
        logic signed [8:0] hq;
        hp = to_half(p);
        hq = to_half(q);
        return sub ? round_q((hp + hp) - (hq + hq)) : round_q((hp + hp) + (hq + hq));
    endfunction

    // cos and -sin of 2*pi*k/32, already rounded to fp4
    always_comb begin
        case (tw_idx)
            4'd0, 4'd1:         w = 8'h20;   // 1
            4'd2, 4'd3:         w = 8'h29;   // 1 - 0.5j
            4'd4:               w = 8'h19;
            4'd5, 4'd6:         w = 8'h1A;
            4'd7, 4'd8, 4'd9:   w = 8'h0A;   // -j
            4'd10, 4'd11:       w = 8'h9A;
            4'd12:              w = 8'h99;
            4'd13, 4'd14:       w = 8'hA9;
            default:            w = 8'hA0;   // k = 15, -1
        endcase
    end

    assign p_rr = fmul(w[7:4], b[7:4]);
    assign p_ii = fmul(w[3:0], b[3:0]);
    assign p_ri = fmul(w[7:4], b[3:0]);
    assign p_ir = fmul(w[3:0], b[7:4]);

    assign wb_re = fadd(p_rr, p_ii, 1'b1);
    assign wb_im = fadd(p_ri, p_ir, 1'b0);

    assign x = {fadd(a[7:4], wb_re, 1'b0), fadd(a[3:0], wb_im, 1'b0)};
    assign y = {fadd(a[7:4], wb_re, 1'b1), fadd(a[3:0], wb_im, 1'b1)};

endmodule

// ==== verilog/fft_agu.sv ====
// ------------------------------------------------
// pair addresses for in-place radix-2 DIT butterflies
// log2n must stay stable from clear to the last step
// ------------------------------------------------
`include "fft_settings.svh"

module fft_agu (
    input logic clk,
    input logic rst,
    agu_if.gen  agu
);
    import fft_pkg::*;

    log2n_t stage_q;   // current stage s, span is 2**s
    addr_t  bfly_q;    // butterfly number inside the stage
    addr_t  half_m1;   // N/2 - 1
    addr_t  offset;    // position inside the group
    addr_t  base;      // first index of the group
    logic   stage_end;

    assign half_m1   = addr_t'((1 << (agu.log2n - 1)) - 1);
    assign stage_end = (bfly_q == half_m1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stage_q <= '0;
            bfly_q  <= '0;
        end else if (agu.clear) begin
            stage_q <= '0;
            bfly_q  <= '0;
        end else if (agu.step) begin
            if (stage_end) begin
                stage_q <= stage_q + 1'b1;   // next stage, span doubles
                bfly_q  <= '0;
            end else begin
                bfly_q <= bfly_q + 1'b1;
            end
        end
    end

    assign offset = bfly_q & addr_t'((1 << stage_q) - 1);
    assign base   = addr_t'((bfly_q >> stage_q) << (stage_q + 1));  // group * 2 * span

    assign agu.idx_a  = base | offset;
    assign agu.idx_b  = (base | offset) + addr_t'(1 << stage_q);
    // W_2span^offset is offset * 16/span in 32nds of a turn
    assign agu.tw_idx = tw_idx_t'(offset << (`FFT_MAX_LOG2N - 1 - stage_q));
    assign agu.last   = stage_end && (stage_q == log2n_t'(agu.log2n - 1'b1));

    // the core has to stop at the final butterfly
    a_no_step_after_last: assert property (@(posedge clk) disable iff (!rst)
        !(agu.step && agu.last));

endmodule

// ==== verilog/sample_memory.sv ====
// ------------------------------------------------
// single bank sample store, one read and one write port
// core side owns the bank while core_busy is high
// ------------------------------------------------
`include "fft_settings.svh"

module sample_memory (
    input  logic    clk,
    input  logic    rst,
    input  logic    core_busy,
    mem_port_if.mem io_port,
    mem_port_if.mem core_port
);
    import fft_pkg::*;

    cplx_t mem_q [`FFT_MAX_N];
    cplx_t rd_q;
    addr_t rd_addr;
    logic  wr_en;
    addr_t wr_addr;
    cplx_t wr_data;

    // port select, no arbitration needed since the owners never overlap
    assign rd_addr = core_busy ? core_port.rd_addr : io_port.rd_addr;
    assign wr_en   = core_busy ? core_port.wr_en   : io_port.wr_en;
    assign wr_addr = core_busy ? core_port.wr_addr : io_port.wr_addr;
    assign wr_data = core_busy ? core_port.wr_data : io_port.wr_data;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_addr] <= wr_data;
        end
        rd_q <= mem_q[rd_addr];   // old data on a same-address write
    end

    assign io_port.rd_data   = rd_q;
    assign core_port.rd_data = rd_q;

    // loading must be over before the core takes the bank
    a_no_io_write_busy: assert property (@(posedge clk) disable iff (!rst)
        !(io_port.wr_en && core_busy));

endmodule

// ==== verilog/fft_ifs.sv ====
// ------------------------------------------------
// memory port and AGU connections inside the FFT
// read data lags the read address by one clock
// ------------------------------------------------

interface mem_port_if;
    import fft_pkg::*;

    addr_t rd_addr;
    cplx_t rd_data;   // registered in the memory
    logic  wr_en;
    addr_t wr_addr;
    cplx_t wr_data;

    modport user (output rd_addr, output wr_en, output wr_addr, output wr_data,
                  input rd_data);
    modport mem  (input rd_addr, input wr_en, input wr_addr, input wr_data,
                  output rd_data);
endinterface

interface agu_if;
    import fft_pkg::*;

    logic    clear;   // back to stage 0, butterfly 0
    logic    step;    // advance one butterfly
    log2n_t  log2n;
    addr_t   idx_a;
    addr_t   idx_b;
    tw_idx_t tw_idx;
    logic    last;    // final butterfly of final stage

    modport ctrl (output clear, output step, output log2n,
                  input idx_a, input idx_b, input tw_idx, input last);
    modport gen  (input clear, input step, input log2n,
                  output idx_a, output idx_b, output tw_idx, output last);
endinterface

// ==== verilog/fft_pkg.sv ====
// ------------------------------------------------
// sample, address and state types of the FP4 FFT
// FP4 is E2M1, sign and magnitude, max magnitude 6
// ------------------------------------------------
`include "fft_settings.svh"

package fft_pkg;

    typedef logic [3:0] fp4_t;    // {sign, exp[1:0], mantissa}
    typedef logic [7:0] cplx_t;   // real part in upper nibble

    typedef logic [`FFT_MAX_LOG2N-1:0] addr_t;             // sample address or count
    typedef logic [$clog2(`FFT_MAX_LOG2N+1)-1:0] log2n_t;  // stages per frame
    typedef logic [`FFT_MAX_LOG2N-2:0] tw_idx_t;           // twiddle angle in 32nds of a turn

    // butterfly scheduler
    typedef enum logic [2:0] {
        IDLE,
        READ_A,
        READ_B,
        COMPUTE,
        WRITE_X,
        WRITE_Y,
        DONE
    } core_state_e;

    // frame handling on the I/O side
    typedef enum logic [1:0] {
        LOAD,
        PROCESS,
        READ
    } io_state_e;

endpackage

// ==== verilog/fft_settings.svh ====
// ------------------------------------------------
// size limits of the FFT, shared by RTL and testbench
// the memory depth must stay 2**FFT_MAX_LOG2N
// ------------------------------------------------
`ifndef FFT_SETTINGS_SVH
`define FFT_SETTINGS_SVH

`define FFT_MAX_LOG2N 5   // largest stage count
`define FFT_MAX_N     32  // sample memory depth

`endif
